// ==== rtl/i2c_pkg.sv ====
package i2c_pkg;

	//////////////////////////////////////////////////////////////////////
	// transceiver operations

	typedef enum logic [2:0] {
		I2C_OP_START   = 3'd0,	// start condition from idle bus
		I2C_OP_RESTART = 3'd1,	// repeated start, scl held low before
		I2C_OP_STOP    = 3'd2,	// stop condition, releases the bus
		I2C_OP_TX_BYTE = 3'd3,	// 8 bits out, ack bit in
		I2C_OP_RX_BYTE = 3'd4	// 8 bits in, ack/nak bit out
	} i2c_opcode_t;

	//////////////////////////////////////////////////////////////////////
	// command and status between helper and transceiver

	// command from helper, 13 bits
	typedef struct packed {
		logic        valid;		// one cycle, only while not busy
		i2c_opcode_t op;
		logic [7:0]  data;		// byte for tx
		logic        ack_last;	// answer rx byte with nak
	} i2c_in_t;

	// status back to helper, 11 bits
	typedef struct packed {
		logic       busy;		// operation in progress
		logic       done;		// last cycle of the operation
		logic [7:0] rx_data;	// received byte, msb first
		logic       nak;		// slave did not ack, valid with done
	} i2c_out_t;

endpackage

// ==== rtl/i2c_transceiver.sv ====
`timescale 1ns/1ps

module i2c_transceiver
	import i2c_pkg::*;
#(
	parameter int unsigned CLK_DIV = 4	// clk cycles per quarter scl period
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     req,
	output logic     ack,
	input  i2c_in_t  cin,
	output i2c_out_t cout,
	input  logic     scl_in,
	input  logic     sda_in,
	output logic     scl_oe,	// high pulls scl low
	output logic     sda_oe		// high pulls sda low
);

	localparam int unsigned DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_RESTART,
		ST_STOP,
		ST_TX,
		ST_RX
	} state_t;

	state_t           state;
	state_t           new_state;	// state for the incoming opcode
	logic [DIV_W-1:0] div_cnt;		// quarter-bit divider
	logic [1:0]       phase;		// quarter within the bit
	logic [3:0]       bit_idx;		// 0..7 data, 8 ack slot
	logic [7:0]       shreg;		// tx data out / rx data in
	logic             nak_reply;	// latched ack_last
	logic             nak;
	logic             tick;
	logic             last_bit;
	logic             op_end;
	logic             accept;
	logic [3:0]       nxt_bit;
	logic             nxt_tx;

	// line levels for one quarter, {scl_low, sda_low}
	// byte bits: scl low in q0 and q3, high in q1 and q2
	function automatic logic [1:0] line_drive(state_t st, logic [1:0] ph,
			logic [3:0] bit_n, logic tx_bit, logic nak_rep);
		logic scl_low;
		logic sda_low;
		scl_low = 1'b0;
		sda_low = 1'b0;
		case (st)
			ST_START: begin
				scl_low = (ph == 2'd3);		// scl idle high until the end
				sda_low = ph[1];			// sda falls at q2
			end
			ST_RESTART: begin
				scl_low = (ph == 2'd0) || (ph == 2'd3);
				sda_low = ph[1];			// released first, then falls
			end
			ST_STOP: begin
				scl_low = (ph == 2'd0);
				sda_low = !ph[1];			// rises at q2 with scl high
			end
			ST_TX: begin
				scl_low = (ph == 2'd0) || (ph == 2'd3);
				sda_low = (bit_n < 4'd8) && !tx_bit;	// ack slot released
			end
			ST_RX: begin
				scl_low = (ph == 2'd0) || (ph == 2'd3);
				sda_low = (bit_n == 4'd8) && !nak_rep;	// our ack
			end
			default: ;
		endcase
		return {scl_low, sda_low};
	endfunction

	always_comb begin
		case (cin.op)
			I2C_OP_START:   new_state = ST_START;
			I2C_OP_RESTART: new_state = ST_RESTART;
			I2C_OP_STOP:    new_state = ST_STOP;
			I2C_OP_TX_BYTE: new_state = ST_TX;
			I2C_OP_RX_BYTE: new_state = ST_RX;
			default:        new_state = ST_IDLE;	// unknown op ignored
		endcase
	end

	assign tick     = (div_cnt == DIV_W'(CLK_DIV - 1));
	assign last_bit = (state == ST_TX || state == ST_RX) ? (bit_idx == 4'd8) : 1'b1;
	assign op_end   = (state != ST_IDLE) && tick && (phase == 2'd3) && last_bit;
	assign accept   = cin.valid && ack && (state == ST_IDLE);	// only while owned
	assign nxt_bit  = (phase == 2'd3) ? bit_idx + 4'd1 : bit_idx;
	assign nxt_tx   = (phase == 2'd3) ? shreg[6] : shreg[7];	// bit after the shift

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= ST_IDLE;
			ack     <= 1'b0;
			scl_oe  <= 1'b0;	// bus released
			sda_oe  <= 1'b0;
			div_cnt <= '0;
			phase   <= '0;
			bit_idx <= '0;
			nak     <= 1'b0;
		end else begin
			ack <= req;		// single client, grant follows req
			if (accept) begin
				state   <= new_state;
				div_cnt <= '0;
				phase   <= '0;
				bit_idx <= '0;
				{scl_oe, sda_oe} <= line_drive(new_state, 2'd0, 4'd0,
					cin.data[7], cin.ack_last);
			end else if (state != ST_IDLE) begin
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
				if (tick) begin
					phase <= phase + 2'd1;
					if (phase == 2'd3)
						bit_idx <= nxt_bit;
					if (op_end)
						state <= ST_IDLE;	// lines hold their last level
					else
						{scl_oe, sda_oe} <= line_drive(state, phase + 2'd1, nxt_bit,
							nxt_tx, nak_reply);
					// ack sample mid high, scl stuck low also counts as nak
					if (phase == 2'd1 && state == ST_TX && bit_idx == 4'd8)
						nak <= sda_in || !scl_in;
				end
			end
		end
	end

	// shift register, msb first both ways
	always_ff @(posedge clk) begin
		if (accept) begin
			shreg     <= cin.data;
			nak_reply <= cin.ack_last;
		end else if (tick) begin
			if (state == ST_TX && phase == 2'd3)
				shreg <= {shreg[6:0], 1'b0};
			else if (state == ST_RX && phase == 2'd1 && bit_idx < 4'd8)
				shreg <= {shreg[6:0], sda_in};	// sample while scl high
		end
	end

	always_comb begin
		cout.busy    = (state != ST_IDLE);
		cout.done    = op_end;
		cout.rx_data = shreg;
		cout.nak     = nak;
	end

	// client waits for done before the next command
	a_no_valid_busy: assert property (@(posedge clk) disable iff (reset)
		cout.busy |-> !cin.valid)
		else $error("command issued while transceiver busy");

	// four-phase, req stays low until the grant has dropped
	a_ack_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(ack) |-> !req)
		else $error("req high while ack fell");

endmodule

// ==== rtl/i2c_register_helper.sv ====
`timescale 1ns/1ps

module i2c_register_helper
	import i2c_pkg::*;
#(
	parameter logic [6:0] DEV_ADDR = 7'h50	// 7-bit device address
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       open,
	input  logic       select,
	input  logic       close,
	input  logic [7:0] addr,
	input  logic [7:0] burst_len,
	output logic       ready,
	output logic       rdata_valid,
	output logic       burst_done,
	output logic       err,
	output logic [7:0] rdata,
	output logic       req,
	input  logic       ack,
	output i2c_in_t    cin,
	input  i2c_out_t   cout
);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_GRANT,		// req high, waiting for ack
		ST_OPEN,		// bus owned, waiting for select or close
		ST_START,
		ST_DEV_W,
		ST_REG,
		ST_RESTART,
		ST_DEV_R,
		ST_RX,
		ST_STOP,
		ST_RELEASE		// req low, waiting for ack to drop
	} state_t;

	state_t      state;
	logic        pending;	// command out, done not yet seen
	logic        close_req;	// close seen mid burst
	logic [7:0]  reg_addr;
	logic [7:0]  remaining;
	logic        in_cmd;
	logic        step;
	i2c_opcode_t cmd_op;
	logic [7:0]  cmd_data;
	logic        cmd_last;

	//////////////////////////////////////////////////////////////////////
	// command for the current step of the burst

	always_comb begin
		in_cmd   = 1'b1;
		cmd_op   = I2C_OP_STOP;
		cmd_data = 8'h00;
		cmd_last = 1'b0;
		case (state)
			ST_START:   cmd_op = I2C_OP_START;
			ST_DEV_W: begin
				cmd_op   = I2C_OP_TX_BYTE;
				cmd_data = {DEV_ADDR, 1'b0};	// write, sets the pointer
			end
			ST_REG: begin
				cmd_op   = I2C_OP_TX_BYTE;
				cmd_data = reg_addr;
			end
			ST_RESTART: cmd_op = I2C_OP_RESTART;
			ST_DEV_R: begin
				cmd_op   = I2C_OP_TX_BYTE;
				cmd_data = {DEV_ADDR, 1'b1};
			end
			ST_RX: begin
				cmd_op   = I2C_OP_RX_BYTE;
				cmd_last = (remaining == 8'd1);	// nak ends the read
			end
			ST_STOP:    cmd_op = I2C_OP_STOP;
			default:    in_cmd = 1'b0;
		endcase
	end

	assign step = pending && cout.done;

	//////////////////////////////////////////////////////////////////////
	// sequencer

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= ST_IDLE;
			req         <= 1'b0;
			ready       <= 1'b0;
			pending     <= 1'b0;
			close_req   <= 1'b0;
			cin.valid   <= 1'b0;
			rdata_valid <= 1'b0;
			burst_done  <= 1'b0;
			err         <= 1'b0;
		end else begin
			cin.valid   <= 1'b0;	// pulses
			rdata_valid <= 1'b0;
			burst_done  <= 1'b0;
			err         <= 1'b0;
			if (close)
				close_req <= 1'b1;
			if (in_cmd && !pending && !cout.busy) begin
				cin.valid    <= 1'b1;
				cin.op       <= cmd_op;
				cin.data     <= cmd_data;
				cin.ack_last <= cmd_last;
				pending      <= 1'b1;
			end
			if (step)
				pending <= 1'b0;
			case (state)
				ST_IDLE: if (open) begin
					req   <= 1'b1;
					state <= ST_GRANT;
				end
				ST_GRANT: if (ack) begin
					ready <= 1'b1;
					state <= ST_OPEN;
				end
				ST_OPEN: if (close || close_req) begin
					ready     <= 1'b0;
					req       <= 1'b0;
					close_req <= 1'b0;
					state     <= ST_RELEASE;
				end else if (select) begin
					reg_addr  <= addr;
					remaining <= burst_len;
					state     <= ST_START;
				end
				ST_START:   if (step) state <= ST_DEV_W;
				ST_DEV_W: if (step) begin
					err   <= cout.nak;
					state <= cout.nak ? ST_STOP : ST_REG;	// abandon on nak
				end
				ST_REG: if (step) begin
					err   <= cout.nak;
					state <= cout.nak ? ST_STOP : ST_RESTART;
				end
				ST_RESTART: if (step) state <= ST_DEV_R;
				ST_DEV_R: if (step) begin
					err   <= cout.nak;
					state <= cout.nak ? ST_STOP : ST_RX;
				end
				ST_RX: if (step) begin
					rdata_valid <= 1'b1;
					rdata       <= cout.rx_data;
					remaining   <= remaining - 8'd1;
					if (remaining == 8'd1)
						state <= ST_STOP;
				end
				ST_STOP: if (step) begin
					burst_done <= 1'b1;
					state      <= ST_OPEN;
				end
				ST_RELEASE: if (!ack) state <= ST_IDLE;	// four-phase complete
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_select_ready: assert property (@(posedge clk) disable iff (reset)
		select |-> ready)
		else $error("select while bus not owned");

endmodule

// ==== rtl/i2c_mac_reader.sv ====
`timescale 1ns/1ps

module i2c_mac_reader
	import i2c_pkg::*;
#(
	parameter logic [2:0]  ADDR_PINS  = 3'b000,	// eeprom address strap
	parameter int unsigned BOOT_DELAY = 64		// clk cycles before first access
) (
	input  logic         clk,
	input  logic         reset,
	output logic         req,
	input  logic         ack,
	output i2c_in_t      cin,
	input  i2c_out_t     cout,
	output logic         ready,
	output logic         done,
	output logic         fail,
	output logic [47:0]  mac,
	output logic [127:0] serial
);

	localparam int unsigned CNT_W = $clog2(BOOT_DELAY + 2);

	typedef enum logic [2:0] {
		ST_BOOT_WAIT,
		ST_WAIT_READY,
		ST_READ_MAC,
		ST_MAC_DONE,
		ST_READ_SERIAL,
		ST_DONE,
		ST_HOLD
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] boot_cnt;
	logic             open;
	logic             select;
	logic             close;
	logic             helper_ready;
	logic             rdata_valid;
	logic [7:0]       rdata;
	logic             burst_done;
	logic             err;
	logic [7:0]       rd_addr;
	logic [7:0]       rd_len;

	//////////////////////////////////////////////////////////////////////
	// register access, one address byte

	i2c_register_helper #(
		.DEV_ADDR({4'b1010, ADDR_PINS})
	) i_helper (
		.clk         (clk),
		.reset       (reset),
		.open        (open),
		.select      (select),
		.close       (close),
		.addr        (rd_addr),
		.burst_len   (rd_len),
		.ready       (helper_ready),
		.rdata_valid (rdata_valid),
		.burst_done  (burst_done),
		.err         (err),
		.rdata       (rdata),
		.req         (req),
		.ack         (ack),
		.cin         (cin),
		.cout        (cout)
	);

	//////////////////////////////////////////////////////////////////////
	// read sequence

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= ST_BOOT_WAIT;
			boot_cnt <= '0;
			open     <= 1'b0;
			select   <= 1'b0;
			close    <= 1'b0;
			ready    <= 1'b0;
			done     <= 1'b0;
			fail     <= 1'b0;
		end else begin
			open   <= 1'b0;
			select <= 1'b0;
			close  <= 1'b0;
			done   <= 1'b0;
			case (state)
				ST_BOOT_WAIT: if (boot_cnt == CNT_W'(BOOT_DELAY)) begin
					open  <= 1'b1;
					state <= ST_WAIT_READY;
				end else begin
					boot_cnt <= boot_cnt + 1'b1;
				end
				ST_WAIT_READY: if (helper_ready && !open) begin
					select  <= 1'b1;
					rd_addr <= 8'h9a;	// mac, 6 bytes
					rd_len  <= 8'd6;
					state   <= ST_READ_MAC;
				end
				ST_READ_MAC: begin
					if (rdata_valid)
						mac <= {mac[39:0], rdata};	// first byte ends up msb
					if (burst_done)
						state <= ST_MAC_DONE;
				end
				ST_MAC_DONE: begin
					select  <= 1'b1;
					rd_addr <= 8'h80;	// serial, 16 bytes
					rd_len  <= 8'd16;
					state   <= ST_READ_SERIAL;
				end
				ST_READ_SERIAL: begin
					if (rdata_valid)
						serial <= {serial[119:0], rdata};
					if (burst_done)
						state <= ST_DONE;
				end
				ST_DONE: begin
					close <= 1'b1;
					done  <= 1'b1;
					ready <= 1'b1;	// stays up
					state <= ST_HOLD;
				end
				default: ;	// hold forever
			endcase
			// a nak anywhere ends the sequence, done still pulses once
			if (err && state != ST_DONE && state != ST_HOLD) begin
				fail  <= 1'b1;
				state <= ST_DONE;
			end
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done longer than one cycle");

endmodule

// ==== rtl/eeprom_id_top.sv ====
`timescale 1ns/1ps

module eeprom_id_top
	import i2c_pkg::*;
#(
	parameter int unsigned CLK_DIV    = 4,		// quarter scl period in clk cycles
	parameter logic [2:0]  ADDR_PINS  = 3'b000,	// eeprom a2..a0 strap
	parameter int unsigned BOOT_DELAY = 64
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         scl_in,
	input  logic         sda_in,
	output logic         scl_oe,
	output logic         sda_oe,
	output logic         ready,
	output logic         done,
	output logic         fail,
	output logic [47:0]  mac,
	output logic [127:0] serial
);

	logic     req;	// helper asks for the bus
	logic     ack;
	i2c_in_t  cin;
	i2c_out_t cout;

	i2c_mac_reader #(
		.ADDR_PINS  (ADDR_PINS),
		.BOOT_DELAY (BOOT_DELAY)
	) i_reader (
		.clk    (clk),
		.reset  (reset),
		.req    (req),
		.ack    (ack),
		.cin    (cin),
		.cout   (cout),
		.ready  (ready),
		.done   (done),
		.fail   (fail),
		.mac    (mac),
		.serial (serial)
	);

	i2c_transceiver #(
		.CLK_DIV (CLK_DIV)
	) i_transceiver (
		.clk    (clk),
		.reset  (reset),
		.req    (req),
		.ack    (ack),
		.cin    (cin),
		.cout   (cout),
		.scl_in (scl_in),
		.sda_in (sda_in),
		.scl_oe (scl_oe),
		.sda_oe (sda_oe)
	);

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real         PERIOD_NS    = 8.0,
	parameter int unsigned RESET_CYCLES = 4
) (
	input  logic restart,	// one cycle high starts a new reset
	output logic clk,
	output logic reset
);

	int unsigned rst_left;	// reset cycles still to go

	initial begin
		clk      = 1'b0;
		reset    = 1'b1;	// power-up reset
		rst_left = RESET_CYCLES - 1;
	end

	always #(PERIOD_NS / 2.0) clk = !clk;

	// reset changes on the falling edge only
	always @(negedge clk) begin
		if (restart)
			rst_left = RESET_CYCLES;
		if (rst_left != 0) begin
			reset    <= 1'b1;
			rst_left = rst_left - 1;
		end else begin
			reset <= 1'b0;
		end
	end

endmodule

// ==== tests/eeprom_i2c_model.sv ====
`timescale 1ns/1ps

module eeprom_i2c_model #(
	parameter logic [6:0] DEV_ADDR = 7'h50	// 7-bit address incl. strap
) (
	input  logic clk,
	input  logic reset,
	input  logic nak_all,	// ignore every address byte
	input  logic scl,
	input  logic sda,
	output logic sda_oe,	// high pulls sda low
	output int   starts,	// start and restart conditions
	output int   stops,
	output int   reads,		// read addresses matched
	output logic last_stop	// last bus condition was a stop
);

	typedef enum logic [2:0] {
		M_IDLE,		// not addressed
		M_ADDR,		// receiving device address
		M_REG,		// receiving register pointer
		M_WDATA,	// write data, acked and dropped
		M_READ		// sending bytes from ptr
	} mstate_t;

	logic [7:0] mem [256];
	mstate_t    state;
	logic       scl_q;
	logic       sda_q;
	logic [7:0] shreg;
	logic [7:0] ptr;
	int         pos_cnt;	// scl rises in this byte, 9 = ack slot
	logic       send_next;

	always @(posedge clk) begin
		if (reset) begin
			state     <= M_IDLE;
			sda_oe    <= 1'b0;
			scl_q     <= 1'b1;
			sda_q     <= 1'b1;
			shreg     <= 8'h00;
			ptr       <= 8'h00;
			pos_cnt   <= 0;
			send_next <= 1'b0;
			starts    <= 0;
			stops     <= 0;
			reads     <= 0;
			last_stop <= 1'b0;
		end else begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda) begin	// start or restart
				state     <= M_ADDR;
				pos_cnt   <= 0;
				sda_oe    <= 1'b0;
				starts    <= starts + 1;
				last_stop <= 1'b0;
			end else if (scl && scl_q && !sda_q && sda) begin	// stop
				state     <= M_IDLE;
				pos_cnt   <= 0;
				sda_oe    <= 1'b0;
				stops     <= stops + 1;
				last_stop <= 1'b1;
			end else if (scl && !scl_q) begin	// scl rise, sample
				pos_cnt <= pos_cnt + 1;
				if (state inside {M_ADDR, M_REG, M_WDATA} && pos_cnt < 8)
					shreg <= {shreg[6:0], sda};
				if (state == M_READ && pos_cnt == 8)
					send_next <= !sda;	// master ack asks for more
			end else if (!scl && scl_q) begin	// scl fall, drive
				if (pos_cnt == 8) begin
					case (state)
						M_ADDR: if (shreg[7:1] == DEV_ADDR && !nak_all) begin
							sda_oe <= 1'b1;
							if (shreg[0]) begin
								reads     <= reads + 1;
								send_next <= 1'b1;
								state     <= M_READ;
							end else begin
								state <= M_REG;
							end
						end else begin
							state <= M_IDLE;	// not us, no ack
						end
						M_REG: begin
							ptr    <= shreg;
							sda_oe <= 1'b1;
							state  <= M_WDATA;
						end
						M_WDATA: sda_oe <= 1'b1;
						default: sda_oe <= 1'b0;	// master answers in ack slot
					endcase
				end else if (pos_cnt == 9) begin
					pos_cnt <= 0;
					if (state == M_READ && send_next) begin
						shreg  <= mem[ptr];
						sda_oe <= !mem[ptr][7];	// msb first
						ptr    <= ptr + 8'd1;
					end else begin
						sda_oe <= 1'b0;
						if (state == M_READ)
							state <= M_IDLE;	// nak ends the read
					end
				end else if (state == M_READ && pos_cnt > 0) begin
					sda_oe <= !shreg[7 - pos_cnt];
				end
			end
		end
	end

endmodule

// ==== tests/tb_eeprom_id_top.sv ====
`timescale 1ns/1ps

module tb_eeprom_id_top;

	localparam int unsigned CLK_DIV     = 4;
	localparam logic [2:0]  ADDR_PINS   = 3'b010;
	localparam int unsigned BOOT_DELAY  = 64;
	localparam int unsigned BIT_CYCLES  = 4 * CLK_DIV;
	localparam int unsigned MARGIN      = 1024;
	localparam int unsigned RUN_CYCLES  = BOOT_DELAY + 26 * BIT_CYCLES + 36 * BIT_CYCLES + MARGIN;
	localparam int unsigned TIMEOUT     = 2 * (2 * RUN_CYCLES);	// both runs, doubled
	localparam int unsigned HOLD_CYCLES = 64;

	logic         clk;
	logic         reset;
	logic         restart;
	logic         nak_all;
	logic         scl_oe;
	logic         sda_oe;
	logic         model_sda_oe;
	logic         scl;
	logic         sda;
	logic         ready;
	logic         done;
	logic         fail;
	logic [47:0]  mac;
	logic [127:0] serial;
	int           starts;
	int           stops;
	int           reads;
	logic         last_stop;
	int           seed;
	int           cycle_count;
	int           done_count;
	int           error_count;
	logic [7:0]   exp_mem [256];	// copy of the eeprom contents
	logic [47:0]  mac_at_done;
	logic [127:0] serial_at_done;
	logic         ready_at_done;
	logic         fail_at_done;

	// pull-ups, any low driver wins
	assign scl = !(scl_oe === 1'b1);
	assign sda = !(sda_oe === 1'b1 || model_sda_oe === 1'b1);

	tb_clock_gen #(
		.PERIOD_NS    (8.0),
		.RESET_CYCLES (4)
	) i_clock (
		.restart (restart),
		.clk     (clk),
		.reset   (reset)
	);

	eeprom_id_top #(
		.CLK_DIV    (CLK_DIV),
		.ADDR_PINS  (ADDR_PINS),
		.BOOT_DELAY (BOOT_DELAY)
	) i_eeprom_id_top (
		.clk    (clk),
		.reset  (reset),
		.scl_in (scl),
		.sda_in (sda),
		.scl_oe (scl_oe),
		.sda_oe (sda_oe),
		.ready  (ready),
		.done   (done),
		.fail   (fail),
		.mac    (mac),
		.serial (serial)
	);

	eeprom_i2c_model #(
		.DEV_ADDR ({4'b1010, ADDR_PINS})
	) i_model (
		.clk       (clk),
		.reset     (reset),
		.nak_all   (nak_all),
		.scl       (scl),
		.sda       (sda),
		.sda_oe    (model_sda_oe),
		.starts    (starts),
		.stops     (stops),
		.reads     (reads),
		.last_stop (last_stop)
	);

	//////////////////////////////////////////////////////////////////////
	// reporting, timeout, done counter

	task automatic report_error(input string msg);
		error_count++;
		$display("FAILED at time %0t: %s", $time, msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT) begin
			$display("timeout: the runs did not finish within %0d cycles", TIMEOUT);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	end

	always @(posedge clk) begin
		if (reset)
			done_count <= 0;
		else if (done)
			done_count <= done_count + 1;	// per run
	end

	// only the master moves sda with scl high, and only for start/stop
	a_sda_while_scl_high: assert property (@(posedge clk) disable iff (reset)
		(scl && $past(scl) && $changed(sda)) |-> $changed(sda_oe))
		else report_error("sda changed while scl high outside start or stop");

	//////////////////////////////////////////////////////////////////////
	// run steps, all sampling on the falling edge

	task automatic wait_reset_release();
		do @(negedge clk); while (reset);
	endtask

	task automatic check_boot_quiet();
		repeat (BOOT_DELAY) begin
			assert (!ready && !done && !fail) else report_error("status high during boot delay");
			assert (!scl_oe && !sda_oe) else report_error("bus driven during boot delay");
			@(negedge clk);
		end
	endtask

	task automatic wait_done();
		while (!done) @(negedge clk);
		mac_at_done    = mac;	// reference for the hold check
		serial_at_done = serial;
		ready_at_done  = ready;
		fail_at_done   = fail;
		assert (ready) else report_error("ready low when done pulsed");
	endtask

	task automatic check_stable();
		assert (mac === mac_at_done) else report_error("mac changed after done");
		assert (serial === serial_at_done) else report_error("serial changed after done");
		assert (ready === ready_at_done && fail === fail_at_done)
			else report_error("ready or fail changed after done");
	endtask

	task automatic check_hold(input int exp_stops);
		@(negedge clk);
		assert (!done) else report_error("done high for more than one cycle");
		while (stops < exp_stops) begin	// nak run still finishing its stop
			check_stable();
			@(negedge clk);
		end
		repeat (HOLD_CYCLES) begin
			check_stable();
			assert (!scl_oe && !sda_oe && scl && sda)
				else report_error("bus not released after done");
			@(negedge clk);
		end
		assert (done_count == 1) else report_error("done did not pulse exactly once");
		assert (stops == exp_stops) else report_error("wrong number of stop conditions");
	endtask

	initial begin
		int i;
		logic [47:0]  exp_mac;
		logic [127:0] exp_serial;
		restart     = 1'b0;
		nak_all     = 1'b0;
		seed        = 70427;
		error_count = 0;
		cycle_count = 0;
		for (i = 0; i < 256; i++) begin
			exp_mem[i]     = 8'($random(seed));
			i_model.mem[i] = exp_mem[i];
		end
		exp_mac    = '0;
		exp_serial = '0;
		for (i = 0; i < 6; i++)
			exp_mac[47 - 8 * i -: 8] = exp_mem[8'h9a + i];	// 0x9a in the top byte
		for (i = 0; i < 16; i++)
			exp_serial[127 - 8 * i -: 8] = exp_mem[8'h80 + i];	// 0x80 in the top byte

		// normal read
		wait_reset_release();
		check_boot_quiet();
		wait_done();
		assert (mac == exp_mac) else report_error("mac differs from eeprom bytes 0x9a..0x9f");
		assert (serial == exp_serial) else report_error("serial differs from bytes 0x80..0x8f");
		assert (!fail) else report_error("fail high in normal run");
		check_hold(2);
		assert (reads == 2 && starts == 4) else report_error("expected two read transactions");

		// every address byte answered with nak
		nak_all <= 1'b1;
		restart <= 1'b1;
		@(negedge clk);
		restart <= 1'b0;
		do @(negedge clk); while (!reset);
		wait_reset_release();
		check_boot_quiet();
		wait_done();
		assert (fail) else report_error("fail low when done pulsed in nak run");
		check_hold(1);
		assert (last_stop && reads == 0 && starts == 1)
			else report_error("nak run did not end in stop");

		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== files.f ====
rtl/i2c_pkg.sv
rtl/i2c_transceiver.sv
rtl/i2c_register_helper.sv
rtl/i2c_mac_reader.sv
rtl/eeprom_id_top.sv
tests/tb_clock_gen.sv
tests/eeprom_i2c_model.sv
tests/tb_eeprom_id_top.sv

// ==== Bender.yml ====
package:
  name: eeprom_id

sources:
  - rtl/i2c_pkg.sv
  - rtl/i2c_transceiver.sv
  - rtl/i2c_register_helper.sv
  - rtl/i2c_mac_reader.sv
  - rtl/eeprom_id_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/eeprom_i2c_model.sv
      - tests/tb_eeprom_id_top.sv
